// ==== src/merge_pkg.sv ====
// --------------------------------------
// Shared definitions for the two-core
// APB request merge subsystem
// --------------------------------------

`default_nettype none

package merge_pkg;

  // Default bus widths, overridable at the top level
  localparam int unsigned AddrWidthDef = 16;
  localparam int unsigned DataWidthDef = 32;

  // Cores feeding the shared downstream port
  localparam int unsigned NumPorts = 2;

  // Originating core of a forwarded transfer
  typedef logic [$clog2(NumPorts)-1:0] src_id_t;

  // Saturating slave-error count
  typedef logic [7:0] err_cnt_t;

  // Per-core port controller FSM
  typedef enum logic [1:0] {P_IDLE, P_WAIT, P_DONE} port_state_t;

  // Downstream requester FSM
  typedef enum logic [1:0] {A_IDLE, A_SETUP, A_ACCESS} arb_state_t;

endpackage

`default_nettype wire

// ==== src/apb_port_ctrl.sv ====
// --------------------------------------
// Per-core APB completer. Captures one
// transfer, holds it as a request and
// returns the response with pready
// --------------------------------------

`default_nettype none

module apb_port_ctrl #(
  parameter int unsigned ADDR_W = merge_pkg::AddrWidthDef,
  parameter int unsigned DATA_W = merge_pkg::DataWidthDef
) (
  input  wire logic              clk_i,
  input  wire logic              rst_i,
  // Upstream APB from the core
  input  wire logic              psel_i,
  input  wire logic              penable_i,
  input  wire logic              pwrite_i,
  input  wire logic [ADDR_W-1:0] paddr_i,
  input  wire logic [DATA_W-1:0] pwdata_i,
  output      logic              pready_o,
  output      logic [DATA_W-1:0] prdata_o,
  output      logic              pslverr_o,
  // Link to the arbiter
  output      logic              req_o,
  output      logic              wr_o,
  output      logic [ADDR_W-1:0] addr_o,
  output      logic [DATA_W-1:0] wdata_o,
  input  wire logic              done_i,
  input  wire logic [DATA_W-1:0] rdata_i,
  input  wire logic              slverr_i
);

  import merge_pkg::*;

  port_state_t       state_q;
  port_state_t       state_d;
  logic              accept;
  logic              wr_q;
  logic [ADDR_W-1:0] addr_q;
  logic [DATA_W-1:0] wdata_q;
  logic [DATA_W-1:0] rdata_q;
  logic              slverr_q;

  // New access phases are only taken while idle
  assign accept = (state_q == P_IDLE) && psel_i && penable_i;

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      P_IDLE:  if (accept) state_d = P_WAIT;
      P_WAIT:  if (done_i) state_d = P_DONE;
      P_DONE:  state_d = P_IDLE;
      default: state_d = P_IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= P_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Request payload, held until the arbiter is done
  always_ff @(posedge clk_i) begin
    if (accept) begin
      wr_q    <= pwrite_i;
      addr_q  <= paddr_i;
      wdata_q <= pwdata_i;
    end
  end

  // Response from the shared port
  always_ff @(posedge clk_i) begin
    if ((state_q == P_WAIT) && done_i) begin
      rdata_q  <= rdata_i;
      slverr_q <= slverr_i;
    end
  end

  assign req_o     = (state_q == P_WAIT);
  assign wr_o      = wr_q;
  assign addr_o    = addr_q;
  assign wdata_o   = wdata_q;
  assign pready_o  = (state_q == P_DONE);
  assign prdata_o  = rdata_q;
  assign pslverr_o = slverr_q;

endmodule

`default_nettype wire

// ==== src/apb_merge_arbiter.sv ====
// --------------------------------------
// Round-robin merge of two held requests
// onto one APB requester, with source tag
// and saturating slave-error counter
// --------------------------------------

`default_nettype none

module apb_merge_arbiter #(
  parameter int unsigned ADDR_W = merge_pkg::AddrWidthDef,
  parameter int unsigned DATA_W = merge_pkg::DataWidthDef
) (
  input  wire logic               clk_i,
  input  wire logic               rst_i,
  // Requests from the port controllers
  input  wire logic               req0_i,
  input  wire logic               wr0_i,
  input  wire logic [ADDR_W-1:0]  addr0_i,
  input  wire logic [DATA_W-1:0]  wdata0_i,
  input  wire logic               req1_i,
  input  wire logic               wr1_i,
  input  wire logic [ADDR_W-1:0]  addr1_i,
  input  wire logic [DATA_W-1:0]  wdata1_i,
  // Shared response, qualified by done
  output      logic               done0_o,
  output      logic               done1_o,
  output      logic [DATA_W-1:0]  rdata_o,
  output      logic               slverr_o,
  // Downstream APB
  output      logic               m_psel_o,
  output      logic               m_penable_o,
  output      logic               m_pwrite_o,
  output      logic [ADDR_W-1:0]  m_paddr_o,
  output      logic [DATA_W-1:0]  m_pwdata_o,
  output      merge_pkg::src_id_t m_psrc_o,
  input  wire logic               m_pready_i,
  input  wire logic [DATA_W-1:0]  m_prdata_i,
  input  wire logic               m_pslverr_i,
  output      merge_pkg::err_cnt_t err_count_o
);

  import merge_pkg::*;

  arb_state_t          state_q;
  src_id_t             src_q;
  src_id_t             last_q;
  src_id_t             grant_idx;
  logic                grant;
  logic                finish;
  logic [NumPorts-1:0] done_q;
  logic [DATA_W-1:0]   rdata_q;
  logic                slverr_q;
  err_cnt_t            err_cnt_q;

  // --------------------------------------
  // Grant selection
  // --------------------------------------

  // No grant while a done pulse is out, the served port still shows req
  assign grant = (state_q == A_IDLE) && (done_q == '0) && (req0_i || req1_i);

  always_comb begin
    if (req0_i && req1_i) begin
      grant_idx = ~last_q;
    end else if (req1_i) begin
      grant_idx = src_id_t'(1);
    end else begin
      grant_idx = src_id_t'(0);
    end
  end

  assign finish = (state_q == A_ACCESS) && m_pready_i;

  // --------------------------------------
  // Downstream transfer FSM
  // --------------------------------------
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= A_IDLE;
      src_q   <= src_id_t'(0);
      // Core 0 wins the first tie
      last_q  <= src_id_t'(1);
      done_q  <= '0;
    end else begin
      done_q <= '0;
      unique case (state_q)
        A_IDLE: begin
          if (grant) begin
            src_q   <= grant_idx;
            last_q  <= grant_idx;
            state_q <= A_SETUP;
          end
        end
        A_SETUP: state_q <= A_ACCESS;
        A_ACCESS: begin
          if (m_pready_i) begin
            done_q[src_q] <= 1'b1;
            state_q       <= A_IDLE;
          end
        end
        default: state_q <= A_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (finish) begin
      rdata_q  <= m_prdata_i;
      slverr_q <= m_pslverr_i;
    end
  end

  // Error counter, stops at all ones
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      err_cnt_q <= '0;
    end else if (finish && m_pslverr_i && (err_cnt_q != '1)) begin
      err_cnt_q <= err_cnt_q + err_cnt_t'(1);
    end
  end

  // Payload stays stable at the winner until its done
  assign m_psel_o    = (state_q != A_IDLE);
  assign m_penable_o = (state_q == A_ACCESS);
  assign m_pwrite_o  = src_q[0] ? wr1_i    : wr0_i;
  assign m_paddr_o   = src_q[0] ? addr1_i  : addr0_i;
  assign m_pwdata_o  = src_q[0] ? wdata1_i : wdata0_i;
  assign m_psrc_o    = src_q;

  assign done0_o     = done_q[0];
  assign done1_o     = done_q[1];
  assign rdata_o     = rdata_q;
  assign slverr_o    = slverr_q;
  assign err_count_o = err_cnt_q;

endmodule

`default_nettype wire

// ==== src/cluster_apb_merge.sv ====
// --------------------------------------
// Two-core APB request merge top level
// --------------------------------------

`default_nettype none

module cluster_apb_merge #(
  parameter int unsigned ADDR_W = merge_pkg::AddrWidthDef,
  parameter int unsigned DATA_W = merge_pkg::DataWidthDef
) (
  input  wire logic                clk_i,
  input  wire logic                rst_i,
  // Core 0
  input  wire logic                s0_psel_i,
  input  wire logic                s0_penable_i,
  input  wire logic                s0_pwrite_i,
  input  wire logic [ADDR_W-1:0]   s0_paddr_i,
  input  wire logic [DATA_W-1:0]   s0_pwdata_i,
  output      logic                s0_pready_o,
  output      logic [DATA_W-1:0]   s0_prdata_o,
  output      logic                s0_pslverr_o,
  // Core 1
  input  wire logic                s1_psel_i,
  input  wire logic                s1_penable_i,
  input  wire logic                s1_pwrite_i,
  input  wire logic [ADDR_W-1:0]   s1_paddr_i,
  input  wire logic [DATA_W-1:0]   s1_pwdata_i,
  output      logic                s1_pready_o,
  output      logic [DATA_W-1:0]   s1_prdata_o,
  output      logic                s1_pslverr_o,
  // Shared downstream port
  output      logic                m_psel_o,
  output      logic                m_penable_o,
  output      logic                m_pwrite_o,
  output      logic [ADDR_W-1:0]   m_paddr_o,
  output      logic [DATA_W-1:0]   m_pwdata_o,
  output      merge_pkg::src_id_t  m_psrc_o,
  input  wire logic                m_pready_i,
  input  wire logic [DATA_W-1:0]   m_prdata_i,
  input  wire logic                m_pslverr_i,
  output      merge_pkg::err_cnt_t err_count_o
);

  logic              req0;
  logic              wr0;
  logic [ADDR_W-1:0] addr0;
  logic [DATA_W-1:0] wdata0;
  logic              done0;
  logic              req1;
  logic              wr1;
  logic [ADDR_W-1:0] addr1;
  logic [DATA_W-1:0] wdata1;
  logic              done1;
  // Response is shared, each port keys on its own done
  logic [DATA_W-1:0] rdata;
  logic              slverr;

  apb_port_ctrl #(.ADDR_W(ADDR_W), .DATA_W(DATA_W)) u_port0 (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .psel_i    (s0_psel_i),
    .penable_i (s0_penable_i),
    .pwrite_i  (s0_pwrite_i),
    .paddr_i   (s0_paddr_i),
    .pwdata_i  (s0_pwdata_i),
    .pready_o  (s0_pready_o),
    .prdata_o  (s0_prdata_o),
    .pslverr_o (s0_pslverr_o),
    .req_o     (req0),
    .wr_o      (wr0),
    .addr_o    (addr0),
    .wdata_o   (wdata0),
    .done_i    (done0),
    .rdata_i   (rdata),
    .slverr_i  (slverr)
  );

  apb_port_ctrl #(.ADDR_W(ADDR_W), .DATA_W(DATA_W)) u_port1 (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .psel_i    (s1_psel_i),
    .penable_i (s1_penable_i),
    .pwrite_i  (s1_pwrite_i),
    .paddr_i   (s1_paddr_i),
    .pwdata_i  (s1_pwdata_i),
    .pready_o  (s1_pready_o),
    .prdata_o  (s1_prdata_o),
    .pslverr_o (s1_pslverr_o),
    .req_o     (req1),
    .wr_o      (wr1),
    .addr_o    (addr1),
    .wdata_o   (wdata1),
    .done_i    (done1),
    .rdata_i   (rdata),
    .slverr_i  (slverr)
  );

  apb_merge_arbiter #(.ADDR_W(ADDR_W), .DATA_W(DATA_W)) u_arbiter (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .req0_i      (req0),
    .wr0_i       (wr0),
    .addr0_i     (addr0),
    .wdata0_i    (wdata0),
    .req1_i      (req1),
    .wr1_i       (wr1),
    .addr1_i     (addr1),
    .wdata1_i    (wdata1),
    .done0_o     (done0),
    .done1_o     (done1),
    .rdata_o     (rdata),
    .slverr_o    (slverr),
    .m_psel_o    (m_psel_o),
    .m_penable_o (m_penable_o),
    .m_pwrite_o  (m_pwrite_o),
    .m_paddr_o   (m_paddr_o),
    .m_pwdata_o  (m_pwdata_o),
    .m_psrc_o    (m_psrc_o),
    .m_pready_i  (m_pready_i),
    .m_prdata_i  (m_prdata_i),
    .m_pslverr_i (m_pslverr_i),
    .err_count_o (err_count_o)
  );

endmodule

`default_nettype wire

// ==== sim/tb_clk_gen.sv ====
// --------------------------------------
// Testbench clock source, period 4
// --------------------------------------

`default_nettype none

module tb_clk_gen #(
  parameter int unsigned HALF_PERIOD = 2
) (
  output logic clk_o
);

  initial clk_o = 1'b0;

  always #HALF_PERIOD clk_o = ~clk_o;

endmodule

`default_nettype wire

// ==== sim/tb_cluster_apb_merge.sv ====
// --------------------------------------
// Testbench for the two-core APB merge:
// bus masters, downstream memory model,
// scoreboard and assertion checks
// --------------------------------------

`default_nettype none

module tb_cluster_apb_merge;

  import merge_pkg::*;

  localparam int unsigned AddrW = 16;
  localparam int unsigned DataW = 32;
  // Top address bit selects the error region of the memory model
  localparam int ErrBit       = AddrW - 1;
  localparam int ResetCycles  = 10;
  localparam int RoundTripMax = 9;
  localparam int ArbRounds    = 4;
  localparam int RandXfers    = 12;
  // Round robin with a tie after core 0, write/read, error region, random traffic
  localparam int NumXfers   = 2 * ArbRounds + 3 + 4 + 5 + 2 * RandXfers;
  // Setup and release add two cycles to each round trip
  localparam int CycleLimit = ResetCycles + NumXfers * (RoundTripMax + 2) + 100;

  logic             clk;
  logic             rst;
  logic             psel    [2];
  logic             penable [2];
  logic             pwrite  [2];
  logic [AddrW-1:0] paddr   [2];
  logic [DataW-1:0] pwdata  [2];
  logic             pready  [2];
  logic [DataW-1:0] prdata  [2];
  logic             pslverr [2];
  logic             m_psel;
  logic             m_penable;
  logic             m_pwrite;
  logic [AddrW-1:0] m_paddr;
  logic [DataW-1:0] m_pwdata;
  src_id_t          m_psrc;
  logic             m_pready;
  logic [DataW-1:0] m_prdata;
  logic             m_pslverr;
  err_cnt_t         err_count;

  // Memory model and scoreboard copy
  logic [DataW-1:0] mem     [64];
  logic [DataW-1:0] ref_mem [64];
  bit               in_access  = 1'b0;
  int               waits_left = 0;

  // Open transfer of each core for source matching
  bit               active    [2];
  logic [AddrW-1:0] cur_addr  [2];
  logic             cur_wr    [2];
  logic [DataW-1:0] cur_wdata [2];
  src_id_t          grant_log [$];

  int issued  [2];
  int up_done [2];
  int ds_done         = 0;
  int stall_cycles    = 0;
  int exp_err_cnt     = 0;
  int errors          = 0;
  int checks          = 0;
  int tests_run       = 0;
  int tests_failed    = 0;
  int errors_at_start = 0;
  int cycle_cnt       = 0;

  tb_clk_gen u_clk_gen (.clk_o(clk));

  cluster_apb_merge #(.ADDR_W(AddrW), .DATA_W(DataW)) u_cluster_apb_merge (
    .clk_i        (clk),
    .rst_i        (rst),
    .s0_psel_i    (psel[0]),
    .s0_penable_i (penable[0]),
    .s0_pwrite_i  (pwrite[0]),
    .s0_paddr_i   (paddr[0]),
    .s0_pwdata_i  (pwdata[0]),
    .s0_pready_o  (pready[0]),
    .s0_prdata_o  (prdata[0]),
    .s0_pslverr_o (pslverr[0]),
    .s1_psel_i    (psel[1]),
    .s1_penable_i (penable[1]),
    .s1_pwrite_i  (pwrite[1]),
    .s1_paddr_i   (paddr[1]),
    .s1_pwdata_i  (pwdata[1]),
    .s1_pready_o  (pready[1]),
    .s1_prdata_o  (prdata[1]),
    .s1_pslverr_o (pslverr[1]),
    .m_psel_o     (m_psel),
    .m_penable_o  (m_penable),
    .m_pwrite_o   (m_pwrite),
    .m_paddr_o    (m_paddr),
    .m_pwdata_o   (m_pwdata),
    .m_psrc_o     (m_psrc),
    .m_pready_i   (m_pready),
    .m_prdata_i   (m_prdata),
    .m_pslverr_i  (m_pslverr),
    .err_count_o  (err_count)
  );

  function automatic logic [DataW-1:0] fill_word(input int idx);
    return 32'h6b00_0000 ^ (32'(idx) * 32'h0001_0003);
  endfunction

  function automatic int word_of(input logic [AddrW-1:0] addr);
    return int'(addr[7:2]);
  endfunction

  // Core whose open transfer carries this address or -1
  function automatic int owner_of(input logic [AddrW-1:0] addr);
    if (active[0] && (cur_addr[0] == addr)) return 0;
    if (active[1] && (cur_addr[1] == addr)) return 1;
    return -1;
  endfunction

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("FAIL t=%0t %s got=%0h exp=%0h", $time, name, got, exp);
    end
  endtask

  task automatic end_test(input string name);
    tests_run++;
    if (errors == errors_at_start) begin
      $display("test %0d %s: ok", tests_run, name);
    end else begin
      tests_failed++;
      $display("test %0d %s: %0d error(s)", tests_run, name, errors - errors_at_start);
    end
    errors_at_start = errors;
  endtask

  // --------------------------------------
  // Core bus masters
  // --------------------------------------

  // Entered and left one time unit after a rising edge
  task automatic apb_access(input int core, input logic wr, input logic [AddrW-1:0] addr,
                            input logic [DataW-1:0] wdata, output logic [DataW-1:0] rdata,
                            output logic slverr);
    issued[core]++;
    cur_addr[core]  = addr;
    cur_wr[core]    = wr;
    cur_wdata[core] = wdata;
    active[core]    = 1'b1;
    psel[core]      = 1'b1;
    penable[core]   = 1'b0;
    pwrite[core]    = wr;
    paddr[core]     = addr;
    pwdata[core]    = wdata;
    @(posedge clk);
    #1;
    penable[core] = 1'b1;
    @(negedge clk);
    while (!pready[core]) @(negedge clk);
    rdata  = prdata[core];
    slverr = pslverr[core];
    @(posedge clk);
    #1;
    psel[core]    = 1'b0;
    penable[core] = 1'b0;
    active[core]  = 1'b0;
  endtask

  task automatic write_check(input int core, input logic [AddrW-1:0] addr,
                             input logic [DataW-1:0] data);
    logic [DataW-1:0] rdata;
    logic             slverr;
    apb_access(core, 1'b1, addr, data, rdata, slverr);
    check_val($sformatf("s%0d_pslverr_o", core), 32'(slverr), 32'(addr[ErrBit]));
    if (addr[ErrBit]) exp_err_cnt++;
    else ref_mem[word_of(addr)] = data;
  endtask

  task automatic read_check(input int core, input logic [AddrW-1:0] addr);
    logic [DataW-1:0] rdata;
    logic             slverr;
    apb_access(core, 1'b0, addr, '0, rdata, slverr);
    check_val($sformatf("s%0d_pslverr_o", core), 32'(slverr), 32'(addr[ErrBit]));
    if (addr[ErrBit]) exp_err_cnt++;
    else check_val($sformatf("s%0d_prdata_o", core), rdata, ref_mem[word_of(addr)]);
  endtask

  // Each core stays in its own half of the memory
  task automatic random_traffic(input int core);
    int               idx;
    logic [AddrW-1:0] addr;
    logic [DataW-1:0] data;
    for (int n = 0; n < RandXfers; n++) begin
      idx  = 32 * core + int'($urandom % 32);
      addr = AddrW'(4 * idx);
      addr[ErrBit] = ($urandom % 5 == 0);
      data = $urandom;
      if ($urandom % 2 == 0) write_check(core, addr, data);
      else read_check(core, addr);
    end
  endtask

  // --------------------------------------
  // Downstream memory model and monitors
  // --------------------------------------
  always @(posedge clk) begin
    #1;
    if (m_pready) begin
      m_pready  = 1'b0;
      m_pslverr = 1'b0;
      m_prdata  = '0;
      in_access = 1'b0;
    end else if (!rst && m_psel && m_penable) begin
      if (!in_access) begin
        in_access  = 1'b1;
        waits_left = int'($urandom % 4);
      end
      if (waits_left == 0) begin
        m_pready  = 1'b1;
        m_pslverr = m_paddr[ErrBit];
        if (!m_paddr[ErrBit] && m_pwrite) mem[m_paddr[7:2]] = m_pwdata;
        if (!m_paddr[ErrBit] && !m_pwrite) m_prdata = mem[m_paddr[7:2]];
      end else begin
        waits_left--;
        stall_cycles++;
      end
    end
  end

  always @(negedge clk) begin
    int owner;
    if (!rst) begin
      if (pready[0]) up_done[0]++;
      if (pready[1]) up_done[1]++;
      if (m_psel && !m_penable) grant_log.push_back(m_psrc);
      if (m_psel && m_penable) begin
        if (m_pready) ds_done++;
        owner = owner_of(m_paddr);
        assert (owner >= 0) else begin
          errors++;
          $display("downstream access to address %0h at t=%0t matches no core", m_paddr, $time);
        end
        if (owner >= 0) begin
          check_val("m_psrc_o", 32'(m_psrc), 32'(owner));
          check_val("m_pwrite_o", 32'(m_pwrite), 32'(cur_wr[owner]));
          if (m_pwrite) check_val("m_pwdata_o", m_pwdata, cur_wdata[owner]);
        end
      end
    end
  end

  // No upstream completion while the shared port is stalled
  stall_no_pready: assert property (@(posedge clk) disable iff (rst)
    (m_psel && m_penable && !m_pready) |-> !(pready[0] || pready[1]))
    else begin
      errors++;
      $display("FAIL t=%0t s0_pready_o/s1_pready_o got=%b%b exp=00", $time, pready[0], pready[1]);
    end

  setup_one_cycle: assert property (@(posedge clk) disable iff (rst)
    (m_psel && !m_penable) |=> (m_psel && m_penable))
    else begin
      errors++;
      $display("downstream setup phase not followed by an access phase at t=%0t", $time);
    end

  initial begin
    while (cycle_cnt < CycleLimit) begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("timeout: transfers still open after %0d cycles", CycleLimit);
    $display("=== FAIL ===");
    $finish;
  end

  // --------------------------------------
  // Test sequence
  // --------------------------------------
  initial begin
    void'($urandom(85219));
    rst       = 1'b1;
    m_pready  = 1'b0;
    m_prdata  = '0;
    m_pslverr = 1'b0;
    for (int k = 0; k < 2; k++) begin
      psel[k]    = 1'b0;
      penable[k] = 1'b0;
      pwrite[k]  = 1'b0;
      paddr[k]   = '0;
      pwdata[k]  = '0;
      active[k]  = 1'b0;
      issued[k]  = 0;
      up_done[k] = 0;
    end
    for (int i = 0; i < 64; i++) begin
      mem[i]     = fill_word(i);
      ref_mem[i] = fill_word(i);
    end
    repeat (ResetCycles) @(posedge clk);
    #1;
    rst = 1'b0;

    @(negedge clk);
    check_val("s0_pready_o", 32'(pready[0]), 32'h0);
    check_val("s1_pready_o", 32'(pready[1]), 32'h0);
    check_val("m_psel_o", 32'(m_psel), 32'h0);
    check_val("m_penable_o", 32'(m_penable), 32'h0);
    check_val("err_count_o", 32'(err_count), 32'h0);
    end_test("reset state");

    // Grants alternate from core 0 while both cores keep requesting
    @(posedge clk);
    #1;
    grant_log.delete();
    fork
      for (int i = 0; i < ArbRounds; i++) begin
        write_check(0, AddrW'(4 * i), 32'h0a00_0000 + 32'(i));
      end
      for (int j = 0; j < ArbRounds; j++) begin
        write_check(1, AddrW'(128 + 4 * j), 32'h1b00_0000 + 32'(j));
      end
    join
    check_val("grant count", 32'(grant_log.size()), 32'(2 * ArbRounds));
    foreach (grant_log[i]) check_val("m_psrc_o", 32'(grant_log[i]), 32'(i % 2));

    // Core 0 served alone, so the following tie goes to core 1
    grant_log.delete();
    write_check(0, 16'h0020, 32'h2c00_0000);
    fork
      write_check(0, 16'h0024, 32'h2c00_0001);
      write_check(1, 16'h00a0, 32'h3d00_0000);
    join
    check_val("grant count", 32'(grant_log.size()), 32'd3);
    foreach (grant_log[i]) check_val("m_psrc_o", 32'(grant_log[i]), 32'(i % 2));
    end_test("round robin");

    fork
      begin
        write_check(0, 16'h0040, 32'h1234_5678);
        read_check(0, 16'h0040);
      end
      begin
        write_check(1, 16'h00c0, 32'h9abc_def0);
        read_check(1, 16'h00c0);
      end
    join
    end_test("write and read back");

    fork
      write_check(0, 16'h8010, 32'hbad0_0001);
      read_check(1, 16'h0084);
    join
    check_val("err_count_o", 32'(err_count), 32'(exp_err_cnt));
    fork
      read_check(1, 16'h8090);
      write_check(0, 16'h0014, 32'h5555_aaaa);
    join
    check_val("err_count_o", 32'(err_count), 32'(exp_err_cnt));
    // Alias of the failed write keeps its old contents
    read_check(0, 16'h0010);
    end_test("error region");

    fork
      random_traffic(0);
      random_traffic(1);
    join
    check_val("s0_pready_o count", 32'(up_done[0]), 32'(issued[0]));
    check_val("s1_pready_o count", 32'(up_done[1]), 32'(issued[1]));
    check_val("m_pready_i count", 32'(ds_done), 32'(issued[0] + issued[1]));
    check_val("err_count_o", 32'(err_count), 32'(exp_err_cnt));
    assert (stall_cycles > 0) else begin
      errors++;
      $display("no downstream wait state was inserted during the run");
    end
    end_test("random wait states");

    $display("tests %0d, failed %0d, checks %0d, errors %0d",
             tests_run, tests_failed, checks, errors);
    if (errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== sim.f ====
src/merge_pkg.sv
src/apb_port_ctrl.sv
src/apb_merge_arbiter.sv
src/cluster_apb_merge.sv
sim/tb_clk_gen.sv
sim/tb_cluster_apb_merge.sv

// ==== Makefile ====
# Verilator build and run of the APB merge testbench

VERILATOR ?= verilator
TOP       ?= tb_cluster_apb_merge
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
LINTFLAGS ?= --lint-only -Wall --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^=== PASS ===$$" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
